// ==== src/rob_settings.svh ====
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Width of register values and of every ROB value field
`define ROB_DATA_WIDTH 16

// Tag width of one ROB entry
// Depth is 2**ROB_TAG_WIDTH entries
`define ROB_TAG_WIDTH 3

`endif

// ==== src/lc3b_rob_pkg.sv ====
`include "rob_settings.svh"

package lc3b_rob_pkg;

	// LC-3b primary opcodes taken from IR[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'b0000, // Conditional branch
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011, // Byte store
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_st   = 4'b0111, // Word store
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011, // Indirect store
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110, // Address known at decode
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef logic [2:0] lc3b_reg; // R0..R7

	// What decode hands to the tail
	typedef struct packed {
		lc3b_opcode                  op;
		lc3b_reg                     dest;
		logic [`ROB_DATA_WIDTH-1:0]  value;   // BR direction in bit 0
		logic                        predict; // Only meaningful for BR
	} rob_dispatch_t;

	// Result broadcast from an execute unit
	typedef struct packed {
		logic [`ROB_TAG_WIDTH-1:0]   tag;
		logic [`ROB_DATA_WIDTH-1:0]  value;
	} rob_complete_t;

	// Forwarded source operand
	typedef struct packed {
		logic [`ROB_DATA_WIDTH-1:0]  value;
		logic                        ready;
	} rob_operand_t;

	// One retired instruction toward the regfile
	typedef struct packed {
		lc3b_opcode                  op;
		lc3b_reg                     dest;
		logic [`ROB_DATA_WIDTH-1:0]  value;
		logic                        writes_reg; // Regfile write enable
	} rob_commit_t;

endpackage

// ==== src/rob_control.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

// Pointer and occupancy bookkeeping for the reorder buffer
module rob_control
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      dispatch_valid, // Decode strobe
	input  logic                      retire,         // Head commits this cycle
	input  logic                      mispredict,     // Retiring BR went the wrong way
	output logic                      write_en,       // Dispatch accepted into tail
	output logic                      clear,          // Wipe all ready bits
	output logic [`ROB_TAG_WIDTH-1:0] head,
	output logic [`ROB_TAG_WIDTH-1:0] tail,
	output logic                      full,
	output logic                      empty
);

	localparam logic [`ROB_TAG_WIDTH:0] depth = 1 << `ROB_TAG_WIDTH;

	// Extra bit tells full apart from empty
	logic [`ROB_TAG_WIDTH:0] count;

	assign full  = (count == depth);
	assign empty = (count == '0);

	// Dropped when full or while the flush is being taken
	assign write_en = dispatch_valid && !full && !mispredict;

	assign clear = mispredict; // Storage drops ready bits on the same edge

	// Tail pointer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tail <= '0;
		else if (mispredict)
			tail <= '0; // Everything younger than the BR is gone
		else if (write_en)
			tail <= tail + 1'b1; // Wraps at depth
	end

	// Head pointer
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			head <= '0;
		else if (mispredict)
			head <= '0;
		else if (retire)
			head <= head + 1'b1;
	end

	// Occupancy
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else if (mispredict)
			count <= '0;
		else
		begin
			case ({write_en, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

// ==== src/rob_storage.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

// Entry arrays of the reorder buffer
// One FIFO style write at the tail and one tagged completion write per cycle
module rob_storage
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        write_en,       // Accepted dispatch
	input  logic                        clear,          // Flush edge
	input  logic                        retire,         // Head leaves on this edge
	input  logic [`ROB_TAG_WIDTH-1:0]   tail,
	input  logic [`ROB_TAG_WIDTH-1:0]   head,
	input  lc3b_rob_pkg::rob_dispatch_t dispatch,
	input  logic                        complete_valid,
	input  lc3b_rob_pkg::rob_complete_t complete,
	input  logic [`ROB_TAG_WIDTH-1:0]   sr1_tag,
	input  logic [`ROB_TAG_WIDTH-1:0]   sr2_tag,
	output lc3b_rob_pkg::rob_dispatch_t head_entry,
	output logic                        head_ready,
	output lc3b_rob_pkg::rob_operand_t  sr1_operand,
	output lc3b_rob_pkg::rob_operand_t  sr2_operand
);

	localparam int depth = 1 << `ROB_TAG_WIDTH;

	// Per entry fields
	lc3b_rob_pkg::lc3b_opcode   op_q    [depth];
	lc3b_rob_pkg::lc3b_reg      dest_q  [depth];
	logic [`ROB_DATA_WIDTH-1:0] value_q [depth];
	logic                       predict_q [depth];
	logic [depth-1:0]           ready_q;

	logic dispatch_ready; // Entry needs no execute unit

	always_comb
	begin
		case (dispatch.op)
			lc3b_rob_pkg::op_br,
			lc3b_rob_pkg::op_lea: dispatch_ready = 1'b1; // Resolved in decode
			default:              dispatch_ready = 1'b0;
		endcase
	end

	// Ready bits
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ready_q <= '0;
		else if (clear)
			ready_q <= '0; // Mispredict wipes the window
		else
		begin
			if (complete_valid)
				ready_q[complete.tag] <= 1'b1;
			if (retire)
				ready_q[head] <= 1'b0; // Slot is free again
			if (write_en)
				ready_q[tail] <= dispatch_ready; // New entry wins
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (complete_valid && !clear)
			value_q[complete.tag] <= complete.value; // Result from execute
		if (write_en)
		begin
			op_q[tail]      <= dispatch.op;
			dest_q[tail]    <= dispatch.dest;
			value_q[tail]   <= dispatch.value; // Direction or address for BR and LEA
			predict_q[tail] <= dispatch.predict;
		end
	end

	// Oldest entry toward retirement
	assign head_entry.op      = op_q[head];
	assign head_entry.dest    = dest_q[head];
	assign head_entry.value   = value_q[head];
	assign head_entry.predict = predict_q[head];
	assign head_ready         = ready_q[head];

	// Forwarding lookups by tag
	assign sr1_operand.value = value_q[sr1_tag];
	assign sr1_operand.ready = ready_q[sr1_tag];
	assign sr2_operand.value = value_q[sr2_tag];
	assign sr2_operand.ready = ready_q[sr2_tag];

endmodule

// ==== src/rob_retire.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

// In-order commit of the head entry
// Purely combinational so commit shows in the same cycle the head turns ready
module rob_retire
(
	input  lc3b_rob_pkg::rob_dispatch_t head_entry,
	input  logic                        head_ready,
	input  logic                        empty,
	output logic                        retire,       // Advance head at next edge
	output logic                        mispredict,   // BR direction disagreed
	output logic                        commit_valid,
	output lc3b_rob_pkg::rob_commit_t   commit
);

	logic is_branch;
	logic has_dest; // Opcode produces a register result

	// Stale ready bits are ignored when nothing is in flight
	assign retire = !empty && head_ready;

	assign commit_valid = retire;

	assign is_branch = (head_entry.op == lc3b_rob_pkg::op_br);

	// Stores and branches leave the regfile alone
	always_comb
	begin
		case (head_entry.op)
			lc3b_rob_pkg::op_br,
			lc3b_rob_pkg::op_st,
			lc3b_rob_pkg::op_stb,
			lc3b_rob_pkg::op_sti: has_dest = 1'b0;
			default:              has_dest = 1'b1;
		endcase
	end

	// Commit record
	assign commit.op         = head_entry.op;
	assign commit.dest       = head_entry.dest;
	assign commit.value      = head_entry.value;
	assign commit.writes_reg = has_dest;

	// Bit 0 of a BR value holds the resolved direction
	assign mispredict = retire && is_branch
		&& (head_entry.value[0] != head_entry.predict);

endmodule

// ==== src/rob_unit.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

// Reorder buffer top for the LC-3b out-of-order core
module rob_unit
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        dispatch_valid,
	input  lc3b_rob_pkg::rob_dispatch_t dispatch,
	input  logic                        complete_valid,
	input  lc3b_rob_pkg::rob_complete_t complete,
	input  logic [`ROB_TAG_WIDTH-1:0]   sr1_tag,
	input  logic [`ROB_TAG_WIDTH-1:0]   sr2_tag,
	output logic [`ROB_TAG_WIDTH-1:0]   dispatch_tag, // Where the next dispatch lands
	output logic                        full,
	output logic                        empty,
	output lc3b_rob_pkg::rob_operand_t  sr1_operand,
	output lc3b_rob_pkg::rob_operand_t  sr2_operand,
	output logic                        commit_valid,
	output lc3b_rob_pkg::rob_commit_t   commit,
	output logic                        flush
);

	logic                        write_en;
	logic                        clear;
	logic                        retire;
	logic                        mispredict;
	logic [`ROB_TAG_WIDTH-1:0]   head;
	logic [`ROB_TAG_WIDTH-1:0]   tail;
	lc3b_rob_pkg::rob_dispatch_t head_entry;
	logic                        head_ready;

	assign dispatch_tag = tail;
	assign flush        = mispredict; // Front end redirects on this

	rob_control u_control (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.retire         (retire),
		.mispredict     (mispredict),
		.write_en       (write_en),
		.clear          (clear),
		.head           (head),
		.tail           (tail),
		.full           (full),
		.empty          (empty)
	);

	rob_storage u_storage (
		.clk            (clk),
		.rst_n          (rst_n),
		.write_en       (write_en),
		.clear          (clear),
		.retire         (retire),
		.tail           (tail),
		.head           (head),
		.dispatch       (dispatch),
		.complete_valid (complete_valid),
		.complete       (complete),
		.sr1_tag        (sr1_tag),
		.sr2_tag        (sr2_tag),
		.head_entry     (head_entry),
		.head_ready     (head_ready),
		.sr1_operand    (sr1_operand),
		.sr2_operand    (sr2_operand)
	);

	rob_retire u_retire (
		.head_entry   (head_entry),
		.head_ready   (head_ready),
		.empty        (empty),
		.retire       (retire),
		.mispredict   (mispredict),
		.commit_valid (commit_valid),
		.commit       (commit)
	);

endmodule

// ==== testbench/rob_unit_assertions.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

// Checks on ROB pointer and occupancy logic
module rob_unit_assertions
(
	input logic                      clk,
	input logic                      rst_n,
	input logic                      full,
	input logic                      empty,
	input logic                      mispredict, // Flush cycle
	input logic [`ROB_TAG_WIDTH:0]   count
);

	localparam int depth = 1 << `ROB_TAG_WIDTH;

	// Both flags at once would mean a corrupt count
	never_full_and_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(full && empty))
		else $error("full and empty are high together");

	// Flush empties the whole window in one edge
	flush_leaves_empty: assert property (@(posedge clk) disable iff (!rst_n)
		mispredict |=> empty)
		else $error("buffer not empty after a flush cycle");

	count_within_depth: assert property (@(posedge clk) disable iff (!rst_n)
		32'(count) <= depth) // Never more entries than slots
		else $error("occupancy count exceeds the depth");

endmodule

bind rob_control rob_unit_assertions u_assertions (
	.clk        (clk),
	.rst_n      (rst_n),
	.full       (full),
	.empty      (empty),
	.mispredict (mispredict),
	.count      (count)
);

// ==== testbench/rob_unit_tb.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_unit_tb;

	// One commit as observed on the DUT outputs
	typedef struct packed {
		lc3b_rob_pkg::lc3b_opcode   op;
		lc3b_rob_pkg::lc3b_reg      dest;
		logic [`ROB_DATA_WIDTH-1:0] value;
		logic                       writes_reg;
		logic                       flush;
	} seen_commit_t;

	localparam int commit_timeout = 50; // Cycles

	logic                        clk;
	logic                        rst_n;
	logic                        dispatch_valid;
	lc3b_rob_pkg::rob_dispatch_t dispatch;
	logic                        complete_valid;
	lc3b_rob_pkg::rob_complete_t complete;
	logic [`ROB_TAG_WIDTH-1:0]   sr1_tag;
	logic [`ROB_TAG_WIDTH-1:0]   sr2_tag;
	logic [`ROB_TAG_WIDTH-1:0]   dispatch_tag;
	logic                        full;
	logic                        empty;
	lc3b_rob_pkg::rob_operand_t  sr1_operand;
	lc3b_rob_pkg::rob_operand_t  sr2_operand;
	logic                        commit_valid;
	lc3b_rob_pkg::rob_commit_t   commit;
	logic                        flush;

	seen_commit_t seen_now;
	seen_commit_t commit_q [$]; // Commits not yet matched to an E line

	lc3b_rob_pkg::lc3b_opcode dispatched_ops [$]; // Opcodes in dispatch order, oldest first

	int          fd;
	int          code;
	logic [7:0]  cmd;
	logic [31:0] a0, a1, a2, a3, a4, a5;
	logic [8*256-1:0] skip_line;

	rob_unit u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch       (dispatch),
		.complete_valid (complete_valid),
		.complete       (complete),
		.sr1_tag        (sr1_tag),
		.sr2_tag        (sr2_tag),
		.dispatch_tag   (dispatch_tag),
		.full           (full),
		.empty          (empty),
		.sr1_operand    (sr1_operand),
		.sr2_operand    (sr2_operand),
		.commit_valid   (commit_valid),
		.commit         (commit),
		.flush          (flush)
	);

	always #4 clk = ~clk; // 8 ns period

	assign seen_now.op         = commit.op;
	assign seen_now.dest       = commit.dest;
	assign seen_now.value      = commit.value;
	assign seen_now.writes_reg = commit.writes_reg;
	assign seen_now.flush      = flush;

	// Commit monitor, mid cycle where outputs are settled
	always @(negedge clk)
	begin
		if (rst_n && commit_valid)
			commit_q.push_back(seen_now);
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "stopping at first error");
		end
	endtask

	// Guards against a short or malformed stimulus line
	task automatic require_fields(input logic [7:0] kind, input int got, input int want);
		if (got != want)
		begin
			$display("stimulus line %c has %0d fields instead of %0d", kind, got, want);
			$display("FAIL: see errors above");
			$fatal(1, "bad stimulus file");
		end
	endtask

	task automatic dispatch_instr(input logic [31:0] op, input logic [31:0] dest,
		input logic [31:0] value, input logic [31:0] predict, input logic [31:0] exp_tag);
		check_value("dispatch_tag", 32'(dispatch_tag), exp_tag); // Tail before the edge
		dispatch_valid   = 1'b1;
		dispatch.op      = lc3b_rob_pkg::lc3b_opcode'(op[3:0]);
		dispatch.dest    = dest[2:0];
		dispatch.value   = value[`ROB_DATA_WIDTH-1:0];
		dispatch.predict = predict[0];
		dispatched_ops.push_back(lc3b_rob_pkg::lc3b_opcode'(op[3:0])); // Retires in this order
		@(negedge clk);
		dispatch_valid = 1'b0; // One cycle strobe
		dispatch       = '0;
	endtask

	task automatic complete_tag(input logic [31:0] tag, input logic [31:0] value);
		complete_valid = 1'b1;
		complete.tag   = tag[`ROB_TAG_WIDTH-1:0];
		complete.value = value[`ROB_DATA_WIDTH-1:0];
		@(negedge clk);
		complete_valid = 1'b0;
		complete       = '0;
	endtask

	task automatic read_operands(input logic [31:0] t1, input logic [31:0] t2,
		input logic [31:0] v1, input logic [31:0] r1,
		input logic [31:0] v2, input logic [31:0] r2);
		sr1_tag = t1[`ROB_TAG_WIDTH-1:0];
		sr2_tag = t2[`ROB_TAG_WIDTH-1:0];
		#1; // Combinational read settles
		check_value("sr1_operand.value", 32'(sr1_operand.value), v1);
		check_value("sr1_operand.ready", 32'(sr1_operand.ready), r1);
		check_value("sr2_operand.value", 32'(sr2_operand.value), v2);
		check_value("sr2_operand.ready", 32'(sr2_operand.ready), r2);
		@(negedge clk); // Back on the drive edge
	endtask

	task automatic expect_commit(input logic [31:0] dest, input logic [31:0] value,
		input logic [31:0] writes_reg, input logic [31:0] exp_flush);
		int                       waited;
		seen_commit_t             got;
		lc3b_rob_pkg::lc3b_opcode exp_op;
		waited = 0;
		while (commit_q.size() == 0 && waited < commit_timeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (commit_q.size() == 0)
		begin
			$display("timeout: no commit seen within %0d cycles", commit_timeout);
			$display("FAIL: see errors above");
			$fatal(1, "commit wait timed out");
		end
		if (dispatched_ops.size() == 0)
		begin
			$display("a commit was expected with no dispatched instruction left");
			$display("FAIL: see errors above");
			$fatal(1, "commit without dispatch");
		end
		got    = commit_q.pop_front();
		exp_op = dispatched_ops.pop_front(); // Oldest one retires first
		check_value("commit.op", 32'(got.op), 32'(exp_op));
		check_value("commit.dest", 32'(got.dest), dest);
		check_value("commit.value", 32'(got.value), value);
		check_value("commit.writes_reg", 32'(got.writes_reg), writes_reg);
		check_value("flush", 32'(got.flush), exp_flush);
		if (exp_flush[0])
			dispatched_ops.delete(); // Younger entries are squashed
	endtask

	task automatic wait_cycles(input logic [31:0] n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_status(input logic [31:0] exp_full, input logic [31:0] exp_empty);
		check_value("full", 32'(full), exp_full);
		check_value("empty", 32'(empty), exp_empty);
	endtask

	// Count of commits seen but not expected yet
	task automatic check_pending(input logic [31:0] n);
		#1; // Monitor on this edge has run
		check_value("pending commits", 32'(commit_q.size()), n);
		@(negedge clk);
	endtask

	initial
	begin
		clk            = 1'b0;
		rst_n          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch       = '0;
		complete_valid = 1'b0;
		complete       = '0;
		sr1_tag        = '0;
		sr2_tag        = '0;
		fd = $fopen("testbench/rob_unit_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file");
			$display("FAIL: see errors above");
			$fatal(1, "no stimulus");
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		code = $fscanf(fd, " %c", cmd);
		while (code == 1)
		begin
			case (cmd)
				"#": code = $fgets(skip_line, fd); // Comment line
				"D":
				begin
					code = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
					require_fields(cmd, code, 5);
					dispatch_instr(a0, a1, a2, a3, a4);
				end
				"C":
				begin
					code = $fscanf(fd, "%h %h", a0, a1);
					require_fields(cmd, code, 2);
					complete_tag(a0, a1);
				end
				"R":
				begin
					code = $fscanf(fd, "%h %h %h %h %h %h", a0, a1, a2, a3, a4, a5);
					require_fields(cmd, code, 6);
					read_operands(a0, a1, a2, a3, a4, a5);
				end
				"E":
				begin
					code = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
					require_fields(cmd, code, 4);
					expect_commit(a0, a1, a2, a3);
				end
				"I":
				begin
					code = $fscanf(fd, "%d", a0);
					require_fields(cmd, code, 1);
					wait_cycles(a0);
				end
				"S":
				begin
					code = $fscanf(fd, "%h %h", a0, a1);
					require_fields(cmd, code, 2);
					check_status(a0, a1);
				end
				"Q":
				begin
					code = $fscanf(fd, "%d", a0);
					require_fields(cmd, code, 1);
					check_pending(a0);
				end
				default:
				begin
					$display("unknown stimulus command %c", cmd);
					$display("FAIL: see errors above");
					$fatal(1, "bad stimulus file");
				end
			endcase
			code = $fscanf(fd, " %c", cmd);
		end
		$fclose(fd);
		if (commit_q.size() != 0)
		begin
			$display("%0d commits appeared that no line expected", commit_q.size());
			$display("FAIL: see errors above");
			$fatal(1, "unexpected commits");
		end
		else
		begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

// ==== rob_unit.f ====
+incdir+src
src/lc3b_rob_pkg.sv
src/rob_control.sv
src/rob_storage.sv
src/rob_retire.sv
src/rob_unit.sv
testbench/rob_unit_assertions.sv
testbench/rob_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the ROB testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module rob_unit_tb \
	-f rob_unit.f \
	-o rob_unit_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/rob_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

# The testbench prints the pass line only when every check held
if grep -q "PASS: all tests" sim.log; then
	exit 0
else
	echo "Pass line not found in sim.log"
	exit 1
fi

// ==== testbench/rob_unit_stimulus.txt ====
# D op dest value predict tag | C tag value | R sr1 sr2 val1 rdy1 val2 rdy2
# E dest value writes_reg flush | I cycles | S full empty | Q pending commits
S 0 1
D 1 1 0000 0 0
D 1 2 0000 0 1
D 1 3 0000 0 2
D 1 4 0000 0 3
D 1 5 0000 0 4
D 1 6 0000 0 5
D 1 7 0000 0 6
D 1 0 0000 0 7
S 1 0
# Younger ADDs finish first, nothing may commit yet
C 2 2222
C 1 1111
I 3
Q 0
R 2 3 2222 1 0000 0
R 1 6 1111 1 0000 0
C 0 1234
E 1 1234 1 0
E 2 1111 1 0
E 3 2222 1 0
I 2
S 0 0
C 5 5555
C 3 3333
C 7 7777
C 4 4444
C 6 6666
E 4 3333 1 0
E 5 4444 1 0
E 6 5555 1 0
E 7 6666 1 0
E 0 7777 1 0
I 2
S 0 1
# LEA, predicted BR and ST
D e 5 3000 0 0
D 0 0 0001 1 1
D 7 2 0000 0 2
C 2 abcd
E 5 3000 1 0
E 0 0001 0 0
E 2 abcd 0 0
I 2
S 0 1
# Mispredicted BR behind a pending ADD, two ADDs get flushed
D 1 6 0000 0 3
D 0 0 0001 0 4
D 1 4 0000 0 5
D 1 5 0000 0 6
C 3 0aaa
E 6 0aaa 1 0
E 0 0001 0 1
I 5
S 0 1
Q 0
D 1 1 0000 0 0
C 0 beef
E 1 beef 1 0
I 2
S 0 1
Q 0
